// ==== src.f ====
+incdir+src
+incdir+bench
src/exm_pkg.sv
src/ex_mem_if.sv
src/ex_alu.sv
src/ex_mem.sv
src/mem_access.sv
src/pipe_ctrl.sv
src/exm_top.sv
bench/tb_exm_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_exm_top -f src.f \
  && ./obj_dir/Vtb_exm_top > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== bench/tb_exm_model.svh ====
`ifndef TB_EXM_MODEL_SVH
`define TB_EXM_MODEL_SVH

int          checks = 0;
int          errors = 0;
logic [31:0] lfsr_state = 32'd35;
logic [31:0] shadow [`EXM_DMEM_WORDS];   // Expected data RAM contents

// Galois LFSR, one step per returned bit
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    r = {r[30:0], lfsr_state[0]};
  end
  return r;
endfunction

function automatic logic [31:0] alu_ref(input exm_pkg::alu_op_e op, input logic [31:0] a,
                                        input logic [31:0] b);
  case (op)
    exm_pkg::ADD:  return a + b;
    exm_pkg::SUB:  return a - b;
    exm_pkg::AND:  return a & b;
    exm_pkg::OR:   return a | b;
    exm_pkg::XOR:  return a ^ b;
    exm_pkg::SLL:  return a << b[4:0];
    exm_pkg::SRL:  return a >> b[4:0];
    exm_pkg::SRA:  return $unsigned($signed(a) >>> b[4:0]);
    exm_pkg::SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    exm_pkg::SLTU: return (a < b) ? 32'd1 : 32'd0;
    exm_pkg::PASS_IMM: return b;
    default:       return 32'd0;
  endcase
endfunction

// Byte or halfword pick with sign or zero extension
function automatic logic [31:0] load_ref(input exm_pkg::mem_op_e op, input logic [31:0] word,
                                         input logic [1:0] off);
  logic [31:0] s;
  s = word >> (8 * off);
  case (op)
    exm_pkg::LH:  return {{16{s[15]}}, s[15:0]};
    exm_pkg::LHU: return {16'd0, s[15:0]};
    exm_pkg::LB:  return {{24{s[7]}}, s[7:0]};
    exm_pkg::LBU: return {24'd0, s[7:0]};
    default:      return word;
  endcase
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
  end
endtask

`endif

// ==== bench/tb_exm_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exm_settings.svh"

module tb_exm_top;

  logic clk, reset_i, issue_valid_i, stall_i, flush_i;
  exm_pkg::alu_op_e alu_op_i;
  exm_pkg::mem_op_e mem_op_i;
  logic [4:0]  rd_idx_i;
  logic [31:0] rs1_data_i, rs2_data_i, imm_data_i, inst_addr_i;
  logic        ready_o, wb_valid_o, trap_o;
  logic [4:0]  wb_rd_idx_o;
  logic [31:0] wb_data_o, trap_addr_o;

  `include "tb_exm_model.svh"

  int          cycle = 0;
  int          stall_left = 0;
  int          exp_c;
  int          test_err;
  logic        drop_next = 1'b0;   // Issue slot killed by a trap
  logic        acc;
  logic [31:0] pc = 32'h1000;
  logic [31:0] words [8];
  logic [4:0]  exp_rd_q [$];
  logic [31:0] exp_data_q [$];
  int          exp_cyc_q [$];
  logic [31:0] exp_trap_q [$];

  exm_top u_exm_top (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // Compare writebacks and traps in order
  always @(negedge clk) begin
    if (!reset_i && wb_valid_o) begin
      if (exp_rd_q.size() == 0) begin
        errors++;
        $display("Unexpected writeback at %0t with nothing outstanding", $time);
      end else begin
        check_value("wb_rd_idx_o", wb_rd_idx_o, exp_rd_q.pop_front());
        check_value("wb_data_o", wb_data_o, exp_data_q.pop_front());
        exp_c = exp_cyc_q.pop_front();
        if (exp_c >= 0) check_value("wb_cycle", cycle, exp_c);
      end
    end
    if (!reset_i && trap_o) begin
      if (exp_trap_q.size() == 0) begin
        errors++;
        $display("Unexpected trap at %0t", $time);
      end else begin
        check_value("trap_addr_o", trap_addr_o, exp_trap_q.pop_front());
      end
    end
  end

  task automatic record_issue(input exm_pkg::alu_op_e aop, input exm_pkg::mem_op_e mop,
                              input logic [4:0] rd, input logic [31:0] rs1, rs2, imm,
                              input logic timed);
    logic [31:0] ea;
    logic [7:0]  w;
    logic        bad;
    int          cyc;
    ea  = rs1 + imm;
    w   = ea[9:2];
    cyc = timed ? cycle + 2 : -1;
    bad = ((mop == exm_pkg::LW || mop == exm_pkg::SW) && ea[1:0] != 2'd0) ||
          ((mop == exm_pkg::LH || mop == exm_pkg::LHU) && ea[0]);
    if (bad) begin
      exp_trap_q.push_back(pc);
      drop_next = 1'b1;
    end else if (mop == exm_pkg::SW || mop == exm_pkg::SB) begin
      if (mop == exm_pkg::SW) shadow[w] = rs2;
      else shadow[w][8*ea[1:0] +: 8] = rs2[7:0];
      exp_rd_q.push_back(5'd0);
      exp_data_q.push_back(32'd0);
      exp_cyc_q.push_back(cyc);
    end else begin
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(mop == exm_pkg::NONE ?
                           alu_ref(aop, rs1, aop == exm_pkg::PASS_IMM ? imm : rs2) :
                           load_ref(mop, shadow[w], ea[1:0]));
      exp_cyc_q.push_back(cyc);
    end
  endtask

  // One clock of stimulus, inputs change 1 ns after the edge
  task automatic drive_cycle(input logic v, input exm_pkg::alu_op_e aop,
                             input exm_pkg::mem_op_e mop, input logic [4:0] rd,
                             input logic [31:0] rs1, rs2, imm, input logic fl,
                             input logic timed, output logic accepted);
    @(posedge clk);
    #1;
    issue_valid_i = v;
    alu_op_i      = aop;
    mem_op_i      = mop;
    rd_idx_i      = rd;
    rs1_data_i    = rs1;
    rs2_data_i    = rs2;
    imm_data_i    = imm;
    inst_addr_i   = pc;
    flush_i       = fl;
    stall_i       = (stall_left > 0);
    if (stall_left > 0) stall_left--;
    #1;
    if (stall_i) check_value("ready_o", ready_o, 1'b0);
    accepted  = v && ready_o && !fl && !drop_next;
    drop_next = 1'b0;
    if (accepted) record_issue(aop, mop, rd, rs1, rs2, imm, timed);
    if (v) pc += 4;
  endtask

  task automatic issue_op(input exm_pkg::alu_op_e aop, input exm_pkg::mem_op_e mop,
                          input logic [4:0] rd, input logic [31:0] rs1, rs2, imm,
                          input logic timed);
    logic ok;
    int   n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < 50) begin
      drive_cycle(1'b1, aop, mop, rd, rs1, rs2, imm, 1'b0, timed, ok);
      n++;
    end
    if (!ok) begin
      errors++;
      $display("Instruction at %0t was never accepted", $time);
    end
  endtask

  task automatic mem_op(input exm_pkg::mem_op_e mop, input logic [4:0] rd,
                        input logic [31:0] ea, input logic [31:0] data, input logic timed);
    logic [31:0] base;
    base = rand_bits(32);
    issue_op(exm_pkg::ADD, mop, rd, base, data, ea - base, timed);
  endtask

  task automatic random_alu(input logic timed);
    issue_op(exm_pkg::alu_op_e'(rand_bits(4) % 11), exm_pkg::NONE, 5'(rand_bits(5)),
             rand_bits(32), rand_bits(32), rand_bits(32), timed);
  endtask

  task automatic drain;
    int n;
    n = 0;
    while ((exp_rd_q.size() != 0 || exp_trap_q.size() != 0) && n < 100) begin
      drive_cycle(1'b0, exm_pkg::ADD, exm_pkg::NONE, 0, 0, 0, 0, 1'b0, 1'b0, acc);
      n++;
    end
    if (n == 100) begin
      errors++;
      $display("Expected writebacks still outstanding after timeout");
    end
  endtask

  task automatic end_test(input string name);
    drain();
    $display("Test %s: %s (%0d errors)", name, errors == test_err ? "ok" : "FAILED",
             errors - test_err);
    test_err = errors;
  endtask

  initial begin
    reset_i = 1'b1;
    {issue_valid_i, stall_i, flush_i} = 3'b000;
    alu_op_i = exm_pkg::ADD;
    mem_op_i = exm_pkg::NONE;
    {rd_idx_i, rs1_data_i, rs2_data_i, imm_data_i, inst_addr_i} = '0;
    test_err = 0;
    repeat (16) @(posedge clk);
    #1 reset_i = 1'b0;
    @(posedge clk);
    #2;
    check_value("wb_valid_o", wb_valid_o, 1'b0);
    check_value("trap_o", trap_o, 1'b0);
    check_value("ready_o", ready_o, 1'b1);
    end_test("reset");

    repeat (40) random_alu(1'b1);
    end_test("alu_back_to_back");

    for (int i = 0; i < 8; i++) begin
      words[i] = {22'd0, 8'(i[2:0] * 8'd29 + rand_bits(5)), 2'b00};
      mem_op(exm_pkg::SW, 5'd3, words[i], rand_bits(32), 1'b1);
    end
    for (int i = 0; i < 8; i++) mem_op(exm_pkg::SB, 5'd4, words[i] + i % 4, rand_bits(32), 1'b1);
    for (int i = 0; i < 8; i++) begin
      mem_op(exm_pkg::LW, 5'd5, words[i], 0, 1'b1);
      mem_op(exm_pkg::LH, 5'd6, words[i] + 2, 0, 1'b1);
      mem_op(exm_pkg::LHU, 5'd7, words[i], 0, 1'b1);
      mem_op(exm_pkg::LB, 5'd8, words[i] + rand_bits(2), 0, 1'b1);
      mem_op(exm_pkg::LBU, 5'd9, words[i] + rand_bits(2), 0, 1'b1);
    end
    end_test("store_load");

    for (int i = 0; i < 30; i++) begin
      stall_left = rand_bits(3);
      case (rand_bits(2))
        2'd0: mem_op(exm_pkg::SB, 5'd2, words[i % 8] + rand_bits(2), rand_bits(32), 1'b0);
        2'd1: mem_op(exm_pkg::LW, 5'd11, words[i % 8], 0, 1'b0);
        default: random_alu(1'b0);
      endcase
    end
    stall_left = 0;
    end_test("stall");

    random_alu(1'b1);   // Older instruction must survive the flush
    drive_cycle(1'b1, exm_pkg::ADD, exm_pkg::SB, 5'd12, words[0], 32'h5a, 0, 1'b1, 1'b0, acc);
    drive_cycle(1'b1, exm_pkg::ADD, exm_pkg::NONE, 5'd13, 1, 2, 0, 1'b1, 1'b0, acc);
    mem_op(exm_pkg::LW, 5'd14, words[0], 0, 1'b1);
    random_alu(1'b1);
    end_test("flush");

    mem_op(exm_pkg::LW, 5'd15, words[1] + 2, 0, 1'b0);
    drive_cycle(1'b1, exm_pkg::ADD, exm_pkg::NONE, 5'd16, 7, 8, 0, 1'b0, 1'b0, acc);
    drive_cycle(1'b0, exm_pkg::ADD, exm_pkg::NONE, 0, 0, 0, 0, 1'b0, 1'b0, acc);
    check_value("ready_o", ready_o, 1'b0);
    drive_cycle(1'b0, exm_pkg::ADD, exm_pkg::NONE, 0, 0, 0, 0, 1'b0, 1'b0, acc);
    check_value("ready_o", ready_o, 1'b1);
    mem_op(exm_pkg::SW, 5'd17, words[2] + 1, 32'hdead, 1'b0);
    drive_cycle(1'b1, exm_pkg::ADD, exm_pkg::NONE, 5'd18, 3, 4, 0, 1'b0, 1'b0, acc);
    drive_cycle(1'b0, exm_pkg::ADD, exm_pkg::NONE, 0, 0, 0, 0, 1'b0, 1'b0, acc);
    check_value("ready_o", ready_o, 1'b0);
    drive_cycle(1'b0, exm_pkg::ADD, exm_pkg::NONE, 0, 0, 0, 0, 1'b0, 1'b0, acc);
    check_value("ready_o", ready_o, 1'b1);
    mem_op(exm_pkg::LW, 5'd19, words[2], 0, 1'b0);
    repeat (4) random_alu(1'b1);
    end_test("misaligned_trap");

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/exm_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exm_settings.svh"

module exm_top (
  input  wire                           clk,
  input  wire                           reset_i,
  input  wire                           issue_valid_i,
  input  exm_pkg::alu_op_e              alu_op_i,
  input  exm_pkg::mem_op_e              mem_op_i,
  input  wire [`EXM_REG_ADDRWIDTH-1:0]  rd_idx_i,
  input  wire [`EXM_XLEN-1:0]           rs1_data_i,
  input  wire [`EXM_XLEN-1:0]           rs2_data_i,
  input  wire [`EXM_XLEN-1:0]           imm_data_i,
  input  wire [`EXM_XLEN-1:0]           inst_addr_i,
  input  wire                           stall_i,
  input  wire                           flush_i,
  output logic                          ready_o,
  output logic                          wb_valid_o,
  output logic [`EXM_REG_ADDRWIDTH-1:0] wb_rd_idx_o,
  output logic [`EXM_XLEN-1:0]          wb_data_o,
  output logic                          trap_o,
  output logic [`EXM_XLEN-1:0]          trap_addr_o
);

  wire stall;
  wire flush;
  wire misalign;

  ex_mem_if ex_if ();    // EX to EX/MEM
  ex_mem_if mem_if ();   // EX/MEM to MEM

  ex_alu u_ex_alu (
    .issue_valid_i(issue_valid_i),
    .alu_op_i     (alu_op_i),
    .mem_op_i     (mem_op_i),
    .rd_idx_i     (rd_idx_i),
    .rs1_data_i   (rs1_data_i),
    .rs2_data_i   (rs2_data_i),
    .imm_data_i   (imm_data_i),
    .inst_addr_i  (inst_addr_i),
    .ex_o         (ex_if.sender)
  );

  ex_mem u_ex_mem (
    .clk    (clk),
    .reset_i(reset_i),
    .stall_i(stall),
    .flush_i(flush),
    .ex_i   (ex_if.receiver),
    .mem_o  (mem_if.sender)
  );

  mem_access u_mem_access (
    .clk        (clk),
    .reset_i    (reset_i),
    .stall_i    (stall),
    .mem_i      (mem_if.receiver),
    .misalign_o (misalign),
    .wb_valid_o (wb_valid_o),
    .wb_rd_idx_o(wb_rd_idx_o),
    .wb_data_o  (wb_data_o),
    .trap_o     (trap_o),
    .trap_addr_o(trap_addr_o)
  );

  pipe_ctrl u_pipe_ctrl (
    .clk       (clk),
    .reset_i   (reset_i),
    .stall_i   (stall_i),
    .flush_i   (flush_i),
    .misalign_i(misalign),
    .stall_o   (stall),
    .flush_o   (flush),
    .ready_o   (ready_o)
  );

endmodule

`default_nettype wire

// ==== src/pipe_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
  input  wire  clk,
  input  wire  reset_i,
  input  wire  stall_i,
  input  wire  flush_i,
  input  wire  misalign_i,
  output logic stall_o,
  output logic flush_o,
  output logic ready_o
);

  exm_pkg::ctrl_state_e state_q;
  exm_pkg::ctrl_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      exm_pkg::RUN: begin
        if (misalign_i) begin
          state_d = exm_pkg::TRAP_DRAIN;
        end
      end
      exm_pkg::TRAP_DRAIN: state_d = exm_pkg::RUN;   // Single drain cycle
      default: state_d = exm_pkg::RUN;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= exm_pkg::RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // Drain cycle clears whatever the issuer presents
  assign flush_o = flush_i | misalign_i | (state_q == exm_pkg::TRAP_DRAIN);
  assign stall_o = stall_i & ~flush_o;   // Flush has priority
  assign ready_o = ~stall_i & (state_q == exm_pkg::RUN);

endmodule

`default_nettype wire

// ==== src/mem_access.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exm_settings.svh"

module mem_access (
  input  wire                           clk,
  input  wire                           reset_i,
  input  wire                           stall_i,
  ex_mem_if.receiver                    mem_i,
  output logic                          misalign_o,
  output logic                          wb_valid_o,
  output logic [`EXM_REG_ADDRWIDTH-1:0] wb_rd_idx_o,
  output logic [`EXM_XLEN-1:0]          wb_data_o,
  output logic                          trap_o,
  output logic [`EXM_XLEN-1:0]          trap_addr_o
);

  localparam int BYTES = `EXM_XLEN / 8;
  localparam int OFFW  = $clog2(BYTES);
  localparam int AW    = $clog2(`EXM_DMEM_WORDS);

  logic [`EXM_XLEN-1:0] dmem [`EXM_DMEM_WORDS];

  logic [`EXM_XLEN-1:0] addr;
  logic [AW-1:0]        word_idx;
  logic [OFFW-1:0]      byte_off;
  logic                 is_load;
  logic                 is_store;
  logic                 misaligned;
  logic                 access_ok;
  logic [BYTES-1:0]     ram_be;
  logic [`EXM_XLEN-1:0] ram_wdata;

  logic                          wb_valid_q;
  exm_pkg::mem_op_e              wb_op_q;
  logic [OFFW-1:0]               wb_off_q;
  logic [`EXM_REG_ADDRWIDTH-1:0] wb_rd_idx_q;
  logic [`EXM_XLEN-1:0]          wb_alu_q;
  logic [`EXM_XLEN-1:0]          rd_word_q;
  logic [`EXM_XLEN-1:0]          ld_shift;
  logic                          trap_q;
  logic [`EXM_XLEN-1:0]          trap_addr_q;

  assign addr     = mem_i.alu_data;
  assign word_idx = addr[OFFW +: AW];   // Wraps modulo RAM size
  assign byte_off = addr[OFFW-1:0];

  always_comb begin
    is_load    = 1'b0;
    is_store   = 1'b0;
    misaligned = 1'b0;
    case (mem_i.mem_op)
      exm_pkg::LW: begin
        is_load    = 1'b1;
        misaligned = |byte_off;
      end
      exm_pkg::LH, exm_pkg::LHU: begin
        is_load    = 1'b1;
        misaligned = byte_off[0];
      end
      exm_pkg::LB, exm_pkg::LBU: is_load = 1'b1;
      exm_pkg::SW: begin
        is_store   = 1'b1;
        misaligned = |byte_off;
      end
      exm_pkg::SB: is_store = 1'b1;
      default: ;
    endcase
  end

  assign misalign_o = mem_i.valid & misaligned;
  assign access_ok  = mem_i.valid & ~misaligned & ~stall_i;

  assign ram_be    = (mem_i.mem_op == exm_pkg::SW) ? '1 : (BYTES'(1) << byte_off);
  assign ram_wdata = (mem_i.mem_op == exm_pkg::SW) ? mem_i.rs2_data
                                                   : {BYTES{mem_i.rs2_data[7:0]}};

  always_ff @(posedge clk) begin
    if (access_ok && is_store) begin
      for (int b = 0; b < BYTES; b++) begin
        if (ram_be[b]) begin
          dmem[word_idx][8*b +: 8] <= ram_wdata[8*b +: 8];
        end
      end
    end
    if (access_ok && is_load) begin
      rd_word_q <= dmem[word_idx];   // Sync read, held on stall
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wb_valid_q <= 1'b0;
      wb_op_q    <= exm_pkg::NONE;
      trap_q     <= 1'b0;
    end else begin
      trap_q <= misalign_o;
      if (stall_i) begin
        wb_valid_q <= 1'b0;          // One pulse per instruction
      end else begin
        wb_valid_q <= mem_i.valid & ~misaligned;
        wb_op_q    <= (mem_i.valid & ~misaligned) ? mem_i.mem_op : exm_pkg::NONE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      wb_off_q    <= byte_off;
      wb_rd_idx_q <= is_store ? '0 : mem_i.rd_idx;
      wb_alu_q    <= mem_i.alu_data;
    end
    if (misalign_o) begin
      trap_addr_q <= mem_i.inst_addr;
    end
  end

  assign ld_shift = rd_word_q >> {wb_off_q, 3'b000};

  always_comb begin
    case (wb_op_q)
      exm_pkg::LW:  wb_data_o = rd_word_q;
      exm_pkg::LH:  wb_data_o = {{(`EXM_XLEN-16){ld_shift[15]}}, ld_shift[15:0]};
      exm_pkg::LHU: wb_data_o = {{(`EXM_XLEN-16){1'b0}}, ld_shift[15:0]};
      exm_pkg::LB:  wb_data_o = {{(`EXM_XLEN-8){ld_shift[7]}}, ld_shift[7:0]};
      exm_pkg::LBU: wb_data_o = {{(`EXM_XLEN-8){1'b0}}, ld_shift[7:0]};
      exm_pkg::SW, exm_pkg::SB: wb_data_o = '0;   // Stores return nothing
      default:      wb_data_o = wb_alu_q;
    endcase
  end

  assign wb_valid_o  = wb_valid_q;
  assign wb_rd_idx_o = wb_rd_idx_q;
  assign trap_o      = trap_q;
  assign trap_addr_o = trap_addr_q;

endmodule

`default_nettype wire

// ==== src/ex_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exm_settings.svh"

module ex_mem (
  input  wire        clk,
  input  wire        reset_i,
  input  wire        stall_i,
  input  wire        flush_i,
  ex_mem_if.receiver ex_i,
  ex_mem_if.sender   mem_o
);

  wire reg_wen = ~stall_i;
  wire reg_clr = reset_i | flush_i;   // Flush wins over stall

  logic                          valid_q;
  logic [`EXM_XLEN-1:0]          inst_addr_q;
  logic [`EXM_REG_ADDRWIDTH-1:0] rd_idx_q;
  logic [`EXM_XLEN-1:0]          alu_data_q;
  logic [`EXM_XLEN-1:0]          rs2_data_q;
  exm_pkg::mem_op_e              mem_op_q;

  always_ff @(posedge clk) begin
    if (reg_clr) begin
      valid_q <= 1'b0;
    end else if (reg_wen) begin
      valid_q <= ex_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_clr) begin
      inst_addr_q <= '0;
    end else if (reg_wen) begin
      inst_addr_q <= ex_i.inst_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_clr) begin
      rd_idx_q <= '0;
    end else if (reg_wen) begin
      rd_idx_q <= ex_i.rd_idx;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_clr) begin
      alu_data_q <= '0;
    end else if (reg_wen) begin
      alu_data_q <= ex_i.alu_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_clr) begin
      rs2_data_q <= '0;
    end else if (reg_wen) begin
      rs2_data_q <= ex_i.rs2_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_clr) begin
      mem_op_q <= exm_pkg::NONE;
    end else if (reg_wen) begin
      mem_op_q <= ex_i.mem_op;
    end
  end

  assign mem_o.valid     = valid_q;
  assign mem_o.inst_addr = inst_addr_q;
  assign mem_o.rd_idx    = rd_idx_q;
  assign mem_o.alu_data  = alu_data_q;
  assign mem_o.rs2_data  = rs2_data_q;
  assign mem_o.mem_op    = mem_op_q;

endmodule

`default_nettype wire

// ==== src/ex_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exm_settings.svh"

module ex_alu (
  input  wire                          issue_valid_i,
  input  exm_pkg::alu_op_e             alu_op_i,
  input  exm_pkg::mem_op_e             mem_op_i,
  input  wire [`EXM_REG_ADDRWIDTH-1:0] rd_idx_i,
  input  wire [`EXM_XLEN-1:0]          rs1_data_i,
  input  wire [`EXM_XLEN-1:0]          rs2_data_i,
  input  wire [`EXM_XLEN-1:0]          imm_data_i,
  input  wire [`EXM_XLEN-1:0]          inst_addr_i,
  ex_mem_if.sender                     ex_o
);

  localparam int SHW = $clog2(`EXM_XLEN);

  logic [`EXM_XLEN-1:0] op_b;
  logic [SHW-1:0]       shamt;
  logic [`EXM_XLEN-1:0] alu_res;
  logic                 is_mem;

  assign is_mem = (mem_op_i != exm_pkg::NONE);
  assign op_b   = (alu_op_i == exm_pkg::PASS_IMM) ? imm_data_i : rs2_data_i;
  assign shamt  = op_b[SHW-1:0];

  always_comb begin
    case (alu_op_i)
      exm_pkg::ADD:      alu_res = rs1_data_i + op_b;
      exm_pkg::SUB:      alu_res = rs1_data_i - op_b;
      exm_pkg::AND:      alu_res = rs1_data_i & op_b;
      exm_pkg::OR:       alu_res = rs1_data_i | op_b;
      exm_pkg::XOR:      alu_res = rs1_data_i ^ op_b;
      exm_pkg::SLL:      alu_res = rs1_data_i << shamt;
      exm_pkg::SRL:      alu_res = rs1_data_i >> shamt;
      exm_pkg::SRA:      alu_res = $signed(rs1_data_i) >>> shamt;
      exm_pkg::SLT: begin
        alu_res = {{(`EXM_XLEN-1){1'b0}}, ($signed(rs1_data_i) < $signed(op_b))};
      end
      exm_pkg::SLTU: begin
        alu_res = {{(`EXM_XLEN-1){1'b0}}, (rs1_data_i < op_b)};
      end
      exm_pkg::PASS_IMM: alu_res = op_b;
      default:           alu_res = '0;   // Unused encodings
    endcase
  end

  assign ex_o.valid     = issue_valid_i;
  assign ex_o.inst_addr = inst_addr_i;
  assign ex_o.rd_idx    = rd_idx_i;
  assign ex_o.alu_data  = is_mem ? (rs1_data_i + imm_data_i) : alu_res;  // EA for loads/stores
  assign ex_o.rs2_data  = rs2_data_i;
  assign ex_o.mem_op    = issue_valid_i ? mem_op_i : exm_pkg::NONE;

endmodule

`default_nettype wire

// ==== src/ex_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exm_settings.svh"

interface ex_mem_if;

  logic                          valid;      // Live instruction in stage
  logic [`EXM_XLEN-1:0]          inst_addr;
  logic [`EXM_REG_ADDRWIDTH-1:0] rd_idx;
  logic [`EXM_XLEN-1:0]          alu_data;   // Result or effective address
  logic [`EXM_XLEN-1:0]          rs2_data;   // Store data
  exm_pkg::mem_op_e              mem_op;

  modport sender (
    output valid,
    output inst_addr,
    output rd_idx,
    output alu_data,
    output rs2_data,
    output mem_op
  );

  modport receiver (
    input valid,
    input inst_addr,
    input rd_idx,
    input alu_data,
    input rs2_data,
    input mem_op
  );

endinterface

`default_nettype wire

// ==== src/exm_pkg.sv ====
`default_nettype none

package exm_pkg;

  typedef enum logic [3:0] {
    ADD      = 4'd0,
    SUB      = 4'd1,
    AND      = 4'd2,
    OR       = 4'd3,
    XOR      = 4'd4,
    SLL      = 4'd5,
    SRL      = 4'd6,
    SRA      = 4'd7,
    SLT      = 4'd8,
    SLTU     = 4'd9,
    PASS_IMM = 4'd10   // Result is the immediate
  } alu_op_e;

  typedef enum logic [2:0] {
    NONE = 3'd0,       // Not a memory op
    LW   = 3'd1,
    LH   = 3'd2,
    LHU  = 3'd3,
    LB   = 3'd4,
    LBU  = 3'd5,
    SW   = 3'd6,
    SB   = 3'd7
  } mem_op_e;

  typedef enum logic {
    RUN        = 1'b0,
    TRAP_DRAIN = 1'b1  // One dead cycle after a trap
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== src/exm_settings.svh ====
`ifndef EXM_SETTINGS_SVH
`define EXM_SETTINGS_SVH

// Data path and address width
`define EXM_XLEN 32

// Destination register index width
`define EXM_REG_ADDRWIDTH 5

// Data RAM depth in words, addresses wrap
`define EXM_DMEM_WORDS 256

`endif
